// ==== verilog/dap_bus_pkg.sv ====
package dap_bus_pkg;

    // Byte address width of the register window
    localparam int addr_width = 12;

    // ------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------
    localparam logic [addr_width-1:0] cr_addr     = 12'h000;
    localparam logic [addr_width-1:0] time_addr   = 12'h004;
    localparam logic [addr_width-1:0] sr_addr     = 12'h008;
    localparam logic [addr_width-1:0] dr_addr     = 12'h00C;
    localparam logic [addr_width-1:0] curcmd_addr = 12'h010;

    // One AHB-Lite address phase as seen by the slave
    typedef struct packed {
        logic                  hsel;
        logic [addr_width-1:0] haddr;
        logic [1:0]            htrans;
        logic [2:0]            hsize;
        logic                  hwrite;
        logic                  hready;
    } ahb_req_t;

    // Register access valid during the data phase
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic                  read_en;
        logic                  write_en;
        logic [3:0]            byte_strobe;
        logic [31:0]           wdata;
    } reg_access_t;

endpackage

// ==== verilog/dap_cmd_pkg.sv ====
package dap_cmd_pkg;

    // CMSIS-DAP command IDs handled in hardware
    typedef enum logic [7:0] {
        cmd_transfer_abort = 8'h07,
        cmd_delay          = 8'h09,
        cmd_queue          = 8'h7E,
        cmd_execute        = 8'h7F
    } dap_cmd_e;

    // Where a decoded command goes
    typedef enum logic [1:0] {
        route_mcu,
        route_delay,
        route_abort,
        route_multi
    } dap_route_e;

    // First-stage dispatch FSM
    typedef enum logic [1:0] {
        st_cmd,
        st_count,
        st_run,
        st_finish
    } dap_state_e;

    localparam int pkt_addr_width = 10;

    // One response buffer write plus the packet length so far
    typedef struct packed {
        logic                      en;
        logic [pkt_addr_width-1:0] addr;
        logic [7:0]                data;
        logic [pkt_addr_width-1:0] len;
    } pkt_write_t;

    typedef struct packed {
        pkt_write_t wr;
        logic       done;
    } worker_out_t;

endpackage

// ==== verilog/dap_ahb_slave.sv ====
module dap_ahb_slave (
    input  logic                     hclk,
    input  logic                     hresetn,
    input  dap_bus_pkg::ahb_req_t    ahb_req,
    input  logic [31:0]              hwdata,
    output dap_bus_pkg::reg_access_t access
);
    import dap_bus_pkg::*;

    logic                  trans_req;
    logic                  read_req;
    logic                  write_req;
    logic                  upd_read;
    logic                  upd_write;
    logic [addr_width-1:0] addr_q;
    logic                  read_en_q;
    logic                  write_en_q;
    logic [3:0]            strobe_q;
    logic [3:0]            strobe_nxt;

    // NONSEQ or SEQ to a selected slave with the bus ready
    assign trans_req = ahb_req.hsel & ahb_req.hready & ahb_req.htrans[1];
    assign read_req  = trans_req & ~ahb_req.hwrite;
    assign write_req = trans_req & ahb_req.hwrite;

    // New request, or end of the transfer in flight
    assign upd_read  = read_req | (read_en_q & ahb_req.hready);
    assign upd_write = write_req | (write_en_q & ahb_req.hready);

    always_comb begin
        case (ahb_req.hsize)
            3'b000:  strobe_nxt = 4'b0001 << ahb_req.haddr[1:0];
            3'b001:  strobe_nxt = ahb_req.haddr[1] ? 4'b1100 : 4'b0011;
            default: strobe_nxt = 4'b1111;
        endcase
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            addr_q     <= '0;
            read_en_q  <= 1'b0;
            write_en_q <= 1'b0;
            strobe_q   <= 4'b0000;
        end else begin
            if (trans_req) begin
                addr_q <= ahb_req.haddr;
            end
            if (upd_read) begin
                read_en_q <= read_req;
            end
            if (upd_write) begin
                write_en_q <= write_req;
            end
            if (upd_read || upd_write) begin
                strobe_q <= strobe_nxt;
            end
        end
    end

    assign access = '{addr: addr_q, read_en: read_en_q, write_en: write_en_q,
                      byte_strobe: strobe_q, wdata: hwdata};

    a_rw_exclusive: assert property (@(posedge hclk) disable iff (!hresetn)
        !(access.read_en && access.write_en));

endmodule

// ==== verilog/dap_regs.sv ====
module dap_regs (
    input  logic                     hclk,
    input  logic                     hresetn,
    input  dap_bus_pkg::reg_access_t access,
    input  logic                     in_valid,
    input  logic [7:0]               in_data,
    input  logic [7:0]               cur_cmd,
    input  logic                     mcu_busy,
    output logic [31:0]              hrdata,
    output logic                     dap_en,
    output logic                     intr,
    output logic                     dr_write,
    output logic                     dr_read,
    output logic                     flag_clear
);
    import dap_bus_pkg::*;

    logic [31:0] ctrl_q;
    logic [31:0] timer_q;

    // Word match, byte offset ignored
    function automatic logic hit(input logic [addr_width-1:0] a,
                                 input logic [addr_width-1:0] base);
        hit = (a[addr_width-1:2] == base[addr_width-1:2]);
    endfunction

    // ------------------------------------------------------------------
    // Control register and timestamp timer
    // ------------------------------------------------------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            ctrl_q <= '0;
        end else if (access.write_en && hit(access.addr, cr_addr)) begin
            for (int i = 0; i < 4; i++) begin
                if (access.byte_strobe[i]) begin
                    ctrl_q[i*8 +: 8] <= access.wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            timer_q <= '0;
        end else if (access.write_en && hit(access.addr, time_addr)) begin
            timer_q <= '0;
        end else begin
            timer_q <= timer_q + 32'd1;
        end
    end

    assign dap_en = ctrl_q[0];
    assign intr   = ctrl_q[31] & mcu_busy;

    // Strobes toward the dispatcher and MCU helper
    assign dr_write   = access.write_en & hit(access.addr, dr_addr) & access.byte_strobe[0];
    assign dr_read    = access.read_en & hit(access.addr, dr_addr);
    assign flag_clear = access.write_en & hit(access.addr, sr_addr)
                        & access.byte_strobe[3] & access.wdata[31];

    // Readback, unmapped words return zero
    always_comb begin
        case (access.addr[addr_width-1:2])
            cr_addr[addr_width-1:2]:     hrdata = ctrl_q;
            time_addr[addr_width-1:2]:   hrdata = timer_q;
            sr_addr[addr_width-1:2]:     hrdata = {mcu_busy, 31'd0};
            dr_addr[addr_width-1:2]:     hrdata = {23'd0, in_valid, in_data};
            curcmd_addr[addr_width-1:2]: hrdata = {24'd0, cur_cmd};
            default:                     hrdata = 32'd0;
        endcase
    end

endmodule

// ==== verilog/dap_dispatcher.sv ====
module dap_dispatcher (
    input  logic                     hclk,
    input  logic                     hresetn,
    input  logic                     dap_en,
    input  logic                     in_valid,
    input  logic [7:0]               in_data,
    input  logic                     dr_read,
    input  logic                     delay_arg_ready,
    input  dap_cmd_pkg::worker_out_t mcu_out,
    input  dap_cmd_pkg::worker_out_t delay_out,
    input  logic                     packet_almost_full,
    output logic                     in_ready,
    output logic [7:0]               cur_cmd,
    output logic                     mcu_start,
    output logic                     delay_start,
    output dap_cmd_pkg::pkt_write_t  pkt,
    output logic                     group_finish,
    output logic                     packet_finish
);
    import dap_cmd_pkg::*;

    dap_state_e  state;
    dap_route_e  route;
    logic [7:0]  dec_byte;
    logic [7:0]  num_cmd;
    logic        group_q;
    logic        packet_q;
    logic        hs;
    logic        run_active;
    worker_out_t sel_out;

    // Decode the live byte while waiting for a command
    assign dec_byte = (state == st_cmd) ? in_data : cur_cmd;

    always_comb begin
        case (dec_byte)
            cmd_transfer_abort:     route = route_abort;
            cmd_delay:              route = route_delay;
            cmd_queue, cmd_execute: route = route_multi;
            default:                route = route_mcu;
        endcase
    end

    assign run_active  = dap_en & (state == st_run);
    assign mcu_start   = run_active & (route == route_mcu);
    assign delay_start = run_active & (route == route_delay);
    assign sel_out     = (route == route_delay) ? delay_out : mcu_out;

    assign in_ready = dap_en & ((state == st_cmd) || (state == st_count)
                                || (delay_start && delay_arg_ready) || dr_read);
    assign hs = in_valid & in_ready;

    // ------------------------------------------------------------------
    // Dispatch FSM
    // ------------------------------------------------------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state    <= st_cmd;
            cur_cmd  <= 8'd0;
            num_cmd  <= 8'd0;
            group_q  <= 1'b0;
            packet_q <= 1'b0;
        end else if (!dap_en) begin
            state    <= st_cmd;
            cur_cmd  <= 8'd0;
            num_cmd  <= 8'd0;
            group_q  <= 1'b0;
            packet_q <= 1'b0;
        end else begin
            group_q  <= 1'b0;
            packet_q <= 1'b0;
            case (state)
                st_cmd: begin
                    if (hs) begin
                        cur_cmd <= in_data;
                        if (route == route_multi) begin
                            state <= st_count;
                        end else if (route != route_abort) begin
                            state <= st_run;
                        end
                    end
                end
                st_count: begin
                    if (hs) begin
                        num_cmd <= in_data;
                        state   <= st_cmd;
                    end
                end
                st_run: begin
                    if (sel_out.done) begin
                        group_q <= 1'b1;
                        state   <= st_finish;
                    end
                end
                default: begin
                    // Hold here while the response buffer is nearly full
                    if (!packet_almost_full) begin
                        if (num_cmd <= 8'd1) begin
                            num_cmd  <= 8'd0;
                            packet_q <= 1'b1;
                        end else begin
                            num_cmd <= num_cmd - 8'd1;
                        end
                        state <= st_cmd;
                    end
                end
            endcase
        end
    end

    // Response routing
    always_comb begin
        pkt          = '0;
        group_finish = 1'b0;
        case (state)
            st_cmd, st_count: begin
                pkt.en       = hs & (route != route_abort);
                pkt.data     = in_data;
                pkt.len      = 10'd1;
                group_finish = pkt.en;
            end
            st_run: begin
                if (dap_en) begin
                    pkt = sel_out.wr;
                end
            end
            default: group_finish = dap_en & group_q;
        endcase
    end

    assign packet_finish = dap_en & packet_q;

    a_no_write_in_finish: assert property (@(posedge hclk) disable iff (!hresetn)
        (state == st_finish) |-> !pkt.en);

endmodule

// ==== verilog/dap_mcu_helper.sv ====
module dap_mcu_helper (
    input  logic                     hclk,
    input  logic                     hresetn,
    input  logic                     start,
    input  logic                     dr_write,
    input  logic                     flag_clear,
    input  logic [7:0]               wdata_byte,
    output dap_cmd_pkg::worker_out_t out
);
    import dap_cmd_pkg::*;

    logic [pkt_addr_width-1:0] wr_addr;
    logic [pkt_addr_width-1:0] wr_len;
    logic                      done_q;

    // Sequential writes only, so length follows the address
    assign wr_len = wr_addr + 10'd1;

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            wr_addr <= '0;
            done_q  <= 1'b0;
        end else if (!start) begin
            wr_addr <= '0;
            done_q  <= 1'b0;
        end else begin
            if (dr_write) begin
                wr_addr <= wr_len;
            end
            if (flag_clear) begin
                done_q <= 1'b1;
            end
        end
    end

    assign out = '{wr: '{en: start & dr_write, addr: wr_addr, data: wdata_byte, len: wr_len},
                   done: done_q};

endmodule

// ==== verilog/dap_delay.sv ====
module dap_delay #(
    parameter int clock_freq_m = 60
) (
    input  logic                     hclk,
    input  logic                     hresetn,
    input  logic                     start,
    input  logic                     in_valid,
    input  logic [7:0]               in_data,
    output logic                     arg_ready,
    output dap_cmd_pkg::worker_out_t out
);
    import dap_cmd_pkg::*;

    localparam int tick_w = $clog2(clock_freq_m + 1);

    typedef enum logic [2:0] {
        dl_arg_lo,
        dl_arg_hi,
        dl_wait,
        dl_done,
        dl_hold
    } dl_state_e;

    dl_state_e         state;
    logic [15:0]       us_left;
    logic [tick_w-1:0] tick;

    assign arg_ready = start & ((state == dl_arg_lo) || (state == dl_arg_hi));

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state <= dl_arg_lo;
        end else if (!start) begin
            state <= dl_arg_lo;
        end else begin
            case (state)
                dl_arg_lo: state <= in_valid ? dl_arg_hi : dl_arg_lo;
                dl_arg_hi: state <= in_valid ? dl_wait : dl_arg_hi;
                dl_wait:   state <= (us_left == 16'd0) ? dl_done : dl_wait;
                dl_done:   state <= dl_hold;
                default:   state <= dl_hold;
            endcase
        end
    end

    // Microsecond countdown, one tick per clock_freq_m cycles
    always_ff @(posedge hclk) begin
        if (arg_ready && in_valid) begin
            if (state == dl_arg_lo) begin
                us_left[7:0] <= in_data;
            end else begin
                us_left[15:8] <= in_data;
                tick          <= '0;
            end
        end else if (state == dl_wait && us_left != 16'd0) begin
            if (tick == tick_w'(clock_freq_m - 1)) begin
                tick    <= '0;
                us_left <= us_left - 16'd1;
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    // Status byte DAP_OK right after the echoed command
    always_comb begin
        out         = '0;
        out.wr.en   = start & (state == dl_done);
        out.wr.addr = pkt_addr_width'(1);
        out.wr.data = 8'h00;
        out.wr.len  = pkt_addr_width'(2);
        out.done    = out.wr.en;
    end

endmodule

// ==== verilog/dap_controller.sv ====
module dap_controller #(
    parameter int clock_freq_m = 60
) (
    input  logic                    hclk,
    input  logic                    hresetn,
    input  dap_bus_pkg::ahb_req_t   ahb_req,
    input  logic [31:0]             hwdata,
    output logic [31:0]             hrdata,
    output logic                    hreadyout,
    output logic                    hresp,
    output logic                    intr,
    input  logic                    in_valid,
    input  logic [7:0]              in_data,
    output logic                    in_ready,
    output dap_cmd_pkg::pkt_write_t pkt,
    output logic                    group_finish,
    output logic                    packet_finish,
    input  logic                    packet_almost_full
);
    import dap_bus_pkg::*;
    import dap_cmd_pkg::*;

    reg_access_t access;
    logic        dap_en;
    logic        dr_write;
    logic        dr_read;
    logic        flag_clear;
    logic [7:0]  cur_cmd;
    logic        mcu_start;
    logic        delay_start;
    logic        delay_arg_ready;
    worker_out_t mcu_out;
    worker_out_t delay_out;

    // No wait states, always OKAY
    assign hreadyout = 1'b1;
    assign hresp     = 1'b0;

    dap_ahb_slave ahb_slave_i (
        .hclk(hclk), .hresetn(hresetn), .ahb_req(ahb_req), .hwdata(hwdata), .access(access)
    );

    dap_regs regs_i (
        .hclk(hclk), .hresetn(hresetn), .access(access),
        .in_valid(in_valid), .in_data(in_data), .cur_cmd(cur_cmd), .mcu_busy(mcu_start),
        .hrdata(hrdata), .dap_en(dap_en), .intr(intr),
        .dr_write(dr_write), .dr_read(dr_read), .flag_clear(flag_clear)
    );

    dap_dispatcher dispatcher_i (
        .hclk(hclk), .hresetn(hresetn), .dap_en(dap_en),
        .in_valid(in_valid), .in_data(in_data), .dr_read(dr_read),
        .delay_arg_ready(delay_arg_ready), .mcu_out(mcu_out), .delay_out(delay_out),
        .packet_almost_full(packet_almost_full), .in_ready(in_ready), .cur_cmd(cur_cmd),
        .mcu_start(mcu_start), .delay_start(delay_start), .pkt(pkt),
        .group_finish(group_finish), .packet_finish(packet_finish)
    );

    // CPU fallback for every command without a hardware worker
    dap_mcu_helper mcu_helper_i (
        .hclk(hclk), .hresetn(hresetn), .start(mcu_start), .dr_write(dr_write),
        .flag_clear(flag_clear), .wdata_byte(access.wdata[7:0]), .out(mcu_out)
    );

    dap_delay #(.clock_freq_m(clock_freq_m)) delay_i (
        .hclk(hclk), .hresetn(hresetn), .start(delay_start),
        .in_valid(in_valid), .in_data(in_data), .arg_ready(delay_arg_ready), .out(delay_out)
    );

endmodule

// ==== tb/tb_dap_controller.sv ====
module tb_dap_controller;
    import dap_bus_pkg::*;
    import dap_cmd_pkg::*;

    localparam int clk_mhz = 2;
    localparam ahb_req_t idle_req = '{hsel: 1'b0, haddr: '0, htrans: 2'b00, hsize: 3'b010,
                                      hwrite: 1'b0, hready: 1'b1};

    logic        hclk;
    logic        hresetn;
    ahb_req_t    ahb_req;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hreadyout;
    logic        hresp;
    logic        intr;
    logic        in_valid;
    logic [7:0]  in_data;
    logic        in_ready;
    pkt_write_t  pkt;
    logic        group_finish;
    logic        packet_finish;
    logic        packet_almost_full;

    logic [31:0] seed = 32'hf760_cd47;
    logic [31:0] cycle = '0;
    logic [31:0] hs_cycle = '0;
    logic [31:0] packet_cycle = '0;
    logic [31:0] exp_q[$];
    logic [7:0]  stream_q[$];
    logic [7:0]  helper_q[$];
    logic [7:0]  delay_cnt[4];
    int          exp_groups = 0;
    int          exp_packets = 0;
    int          got_groups = 0;
    int          got_packets = 0;
    int          errors = 0;
    int          checks = 0;
    int          limit = 0;
    logic        limit_ready = 1'b0;

    dap_controller #(.clock_freq_m(clk_mhz)) dut_i (
        .hclk(hclk), .hresetn(hresetn), .ahb_req(ahb_req), .hwdata(hwdata),
        .hrdata(hrdata), .hreadyout(hreadyout), .hresp(hresp), .intr(intr),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready), .pkt(pkt),
        .group_finish(group_finish), .packet_finish(packet_finish),
        .packet_almost_full(packet_almost_full)
    );

    initial begin
        hclk = 1'b0;
        forever #50 hclk = ~hclk;
    end

    always @(posedge hclk) cycle <= cycle + 32'd1;

    // LCG for bus data and delay counts
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] write_word(input logic [9:0] addr, input logic [7:0] data,
                                               input logic [9:0] len);
        return {4'd0, addr, data, len};
    endfunction

    // ------------------------------------------------------------------
    // Reference model of the response stream
    // ------------------------------------------------------------------
    function automatic void expected_response();
        int         i;
        int         k;
        int         remaining;
        logic [7:0] c;
        i = 0;
        remaining = 0;
        exp_q.delete();
        exp_groups = 0;
        exp_packets = 0;
        while (i < stream_q.size()) begin
            c = stream_q[i];
            i++;
            if (c != 8'h07) begin
                // Every accepted command byte is echoed at address 0
                exp_q.push_back(write_word(10'd0, c, 10'd1));
                exp_groups++;
                if (c == 8'h7E || c == 8'h7F) begin
                    remaining = int'(stream_q[i]);
                    exp_q.push_back(write_word(10'd0, stream_q[i], 10'd1));
                    exp_groups++;
                    i++;
                end else begin
                    if (c == 8'h09) begin
                        i += 2;
                        exp_q.push_back(write_word(10'd1, 8'h00, 10'd2));
                    end else begin
                        for (k = 0; k < helper_q.size(); k++) begin
                            exp_q.push_back(write_word(10'(k), helper_q[k], 10'(k + 1)));
                        end
                    end
                    exp_groups++;
                    if (remaining <= 1) begin
                        remaining = 0;
                        exp_packets++;
                    end else begin
                        remaining--;
                    end
                end
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (exp === got) else begin
            errors++;
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR %s", what);
        end
    endtask

    // Compares each packet write against the model, counts finish pulses
    always @(negedge hclk) begin
        if (hresetn) begin
            if (pkt.en) begin
                if (exp_q.size() == 0) begin
                    check_true(1'b0, "packet write appeared where none was expected");
                end else begin
                    check_value("packet write", exp_q.pop_front(),
                                {4'd0, pkt.addr, pkt.data, pkt.len});
                end
            end
            if (group_finish) got_groups++;
            if (packet_finish) begin
                got_packets++;
                packet_cycle = cycle;
            end
            if (in_valid && in_ready) hs_cycle = cycle;
        end
    end

    // ------------------------------------------------------------------
    // Bus and stream drivers
    // ------------------------------------------------------------------
    task automatic bus_write(input logic [11:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
        @(posedge hclk);
        ahb_req <= '{hsel: 1'b1, haddr: addr, htrans: 2'b10, hsize: size,
                     hwrite: 1'b1, hready: 1'b1};
        @(posedge hclk);
        ahb_req <= idle_req;
        hwdata  <= data;
        @(posedge hclk);
    endtask

    task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge hclk);
        ahb_req <= '{hsel: 1'b1, haddr: addr, htrans: 2'b10, hsize: 3'b010,
                     hwrite: 1'b0, hready: 1'b1};
        @(posedge hclk);
        ahb_req <= idle_req;
        @(negedge hclk);
        data = hrdata;
        // No wait states and an OKAY response on every transfer
        check_value("bus hreadyout", 32'd1, {31'd0, hreadyout});
        check_value("bus hresp", 32'd0, {31'd0, hresp});
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge hclk);
        in_valid <= 1'b1;
        in_data  <= b;
        @(negedge hclk);
        while (!in_ready) @(negedge hclk);
        @(posedge hclk);
        in_valid <= 1'b0;
    endtask

    task automatic begin_test();
        got_groups  = 0;
        got_packets = 0;
        expected_response();
    endtask

    task automatic finish_test(input string name);
        while (got_packets < exp_packets) @(posedge hclk);
        repeat (4) @(posedge hclk);
        check_true(exp_q.size() == 0, {name, ": expected packet writes are missing"});
        check_value({name, " group_finish count"}, exp_groups, got_groups);
        check_value({name, " packet_finish count"}, exp_packets, got_packets);
    endtask

    // Ends a run that stalls
    initial begin
        wait (limit_ready);
        repeat (limit) @(posedge hclk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] data;
        logic [31:0] cr_model;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] c1;
        int          sum;
        hresetn            = 1'b0;
        ahb_req            = idle_req;
        hwdata             = '0;
        in_valid           = 1'b0;
        in_data            = '0;
        packet_almost_full = 1'b0;
        sum = 0;
        for (int i = 0; i < 4; i++) begin
            data = next_random();
            delay_cnt[i] = {5'd0, data[18:16]};
            sum += int'(delay_cnt[i]) * clk_mhz;
        end
        limit = sum + 2000;
        limit_ready = 1'b1;
        repeat (2) @(posedge hclk);
        hresetn <= 1'b1;

        // Control register, merged per byte lane while disabled
        @(posedge hclk);
        in_valid <= 1'b1;
        in_data  <= 8'h55;
        data = next_random() & 32'hffff_fffe;
        bus_write(cr_addr, 3'b010, data);
        cr_model = data;
        data = next_random() | 32'h8000_0000;
        bus_write(cr_addr + 12'd2, 3'b001, data);
        cr_model[31:16] = data[31:16];
        data = next_random();
        bus_write(cr_addr + 12'd1, 3'b000, data);
        cr_model[15:8] = data[15:8];
        bus_read(cr_addr, rd);
        check_value("cr readback", cr_model, rd);
        check_value("cr intr while disabled", 32'd0, {31'd0, intr});
        check_value("cr in_ready while disabled", 32'd0, {31'd0, in_ready});
        @(posedge hclk);
        in_valid <= 1'b0;
        bus_write(cr_addr, 3'b010, 32'h8000_0001);

        // Timer
        bus_read(time_addr, t1);
        c1 = cycle;
        data = next_random();
        repeat (int'(data[20:17])) @(posedge hclk);
        bus_read(time_addr, t2);
        check_value("timer delta", cycle - c1, t2 - t1);
        bus_write(time_addr, 3'b010, 32'd0);
        bus_read(time_addr, rd);
        check_true(rd < t2, "timer did not restart after a TIME write");

        // MCU helper with unknown command 0x00
        stream_q = '{8'h00};
        helper_q.delete();
        for (int i = 0; i < 3; i++) begin
            data = next_random();
            helper_q.push_back(data[23:16]);
        end
        begin_test();
        send_byte(8'h00);
        repeat (2) @(posedge hclk);
        @(negedge hclk);
        check_value("mcu intr raised", 32'd1, {31'd0, intr});
        bus_read(sr_addr, rd);
        check_value("mcu sr busy", 32'd1, {31'd0, rd[31]});
        bus_read(curcmd_addr, rd);
        check_value("mcu curcmd", 32'h0000_0000, rd);
        for (int i = 0; i < 2; i++) begin
            data = next_random();
            @(posedge hclk);
            in_valid <= 1'b1;
            in_data  <= data[15:8];
            bus_read(dr_addr, rd);
            check_value("mcu dr argument", {23'd0, 1'b1, data[15:8]}, rd);
            @(posedge hclk);
            in_valid <= 1'b0;
        end
        foreach (helper_q[i]) bus_write(dr_addr, 3'b010, {24'd0, helper_q[i]});
        bus_write(sr_addr, 3'b010, 32'h8000_0000);
        finish_test("mcu");
        @(negedge hclk);
        check_value("mcu intr cleared", 32'd0, {31'd0, intr});

        // Single Delay
        stream_q = '{8'h09, delay_cnt[0], 8'h00};
        begin_test();
        foreach (stream_q[i]) send_byte(stream_q[i]);
        finish_test("delay");
        check_true((packet_cycle - hs_cycle) >= 32'(delay_cnt[0]) * 32'(clk_mhz),
                   "delay response came before the requested wait had passed");

        // ExecuteCommands with two Delays
        stream_q = '{8'h7F, 8'h02, 8'h09, delay_cnt[1], 8'h00, 8'h09, delay_cnt[2], 8'h00};
        begin_test();
        foreach (stream_q[i]) send_byte(stream_q[i]);
        finish_test("execute");

        // Lone TransferAbort
        stream_q = '{8'h07};
        begin_test();
        send_byte(8'h07);
        repeat (10) @(posedge hclk);
        finish_test("abort");

        // Back-pressure holds the packet finish
        @(posedge hclk);
        packet_almost_full <= 1'b1;
        stream_q = '{8'h09, delay_cnt[3], 8'h00};
        begin_test();
        foreach (stream_q[i]) send_byte(stream_q[i]);
        while (got_groups < exp_groups) @(posedge hclk);
        repeat (20) @(posedge hclk);
        check_value("backpressure held finish", 32'd0, got_packets);
        packet_almost_full <= 1'b0;
        finish_test("backpressure");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
verilog/dap_bus_pkg.sv
verilog/dap_cmd_pkg.sv
verilog/dap_ahb_slave.sv
verilog/dap_regs.sv
verilog/dap_dispatcher.sv
verilog/dap_mcu_helper.sv
verilog/dap_delay.sv
verilog/dap_controller.sv
tb/tb_dap_controller.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dap_controller \
    -f project.f --Mdir obj_dir -o tb_dap_controller
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_dap_controller > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$log"; then
    exit 1
fi
exit 0
